// File: spi_settings.svh
`ifndef SPI_SETTINGS_SVH
`define SPI_SETTINGS_SVH

// Register map on the 2-bit bus address
`define SPI_CTRL 2'd0
`define SPI_STAT 2'd1
`define SPI_DATA 2'd2

// CTRL bit positions
`define SPI_CTRL_PR_LSB 0 // Rate select, low bit
`define SPI_CTRL_PR_MSB 2 // Rate select, high bit
`define SPI_CTRL_CPHA 3
`define SPI_CTRL_CPOL 4
`define SPI_CTRL_IE 5 // Interrupt on RXNE
`define SPI_CTRL_EN 7

// Bit 6 is not implemented and reads as zero
`define SPI_CTRL_MASK 8'hbf

// STAT bit positions
`define SPI_STAT_TXE 0 // Transmit buffer empty
`define SPI_STAT_RXNE 1 // Receive register full
`define SPI_STAT_BUSY 2 // Shifter active

`define SPI_STAT_MASK 8'h07

// Prescaler counter width
`define SPI_PR_N 8

// Half-period ticks in one byte, two per bit
`define SPI_XFER_TICKS 5'd16

`endif

// File: spi_pkg.sv
package spi_pkg;

// One access on the peripheral bus
typedef struct packed {
	logic sel; // Peripheral selected
	logic we; // Write when high, read when low
	logic [1:0] addr; // Register address
	logic [7:0] wdata; // Write data
} pbus_req_t;

// Fields decoded from the CTRL register
typedef struct packed {
	logic enabled; // EN
	logic cpha; // Clock phase
	logic cpol; // Clock idle level
	logic ie; // Interrupt enable
	logic [2:0] pr_sel; // Rate select
} spi_ctrl_t;

// Shifter report back to the register file
typedef struct packed {
	logic busy; // Transfer in progress
	logic loaded; // One cycle, TX byte taken
	logic done; // One cycle, 8 bits complete
	logic [7:0] rx_byte; // Received byte, valid with done
} shift_stat_t;

endpackage

// File: prescaler.sv
`timescale 1ns/1ns
`include "spi_settings.svh"

module prescaler
	import spi_pkg::*;
(
	input logic sys,
	input logic n_sh_reset,
	input spi_ctrl_t ctrl,
	output logic tick
);

logic [`SPI_PR_N-1:0] count;
logic [`SPI_PR_N-1:0] count_next;

assign count_next = count + `SPI_PR_N'(1);

// Bit k falls once every 2^(k+1) cycles, which gives the sck half period
always_ff @(posedge sys) begin
	if (!n_sh_reset || !ctrl.enabled) begin
		count <= '0; // Fixed phase on each enable
		tick <= 1'b0;
	end else begin
		count <= count_next;
		tick <= count[ctrl.pr_sel] & ~count_next[ctrl.pr_sel]; // Falling edge of selected bit
	end
end

endmodule

// File: spi_regs.sv
`timescale 1ns/1ns
`include "spi_settings.svh"

module spi_regs
	import spi_pkg::*;
(
	input logic sys,
	input logic n_sh_reset,
	input pbus_req_t bus,
	output logic [7:0] rdata,
	output spi_ctrl_t ctrl,
	output logic [7:0] tx_byte,
	output logic tx_valid,
	input shift_stat_t stat,
	output logic irq
);

logic [7:0] ctrl_q;
logic [7:0] tx_buf;
logic [7:0] rx_buf;
logic [7:0] stat_word;
logic txe;
logic txe_d;
logic rxne;
logic rxne_d;
logic wr;
logic rd;
logic wr_ctrl;
logic wr_data;
logic rd_data;

// Bus decode
assign wr = bus.sel & bus.we;
assign rd = bus.sel & ~bus.we;
assign wr_ctrl = wr && (bus.addr == `SPI_CTRL);
assign wr_data = wr && (bus.addr == `SPI_DATA);
assign rd_data = rd && (bus.addr == `SPI_DATA);

// Decoded control fields
assign ctrl.enabled = ctrl_q[`SPI_CTRL_EN];
assign ctrl.cpha = ctrl_q[`SPI_CTRL_CPHA];
assign ctrl.cpol = ctrl_q[`SPI_CTRL_CPOL];
assign ctrl.ie = ctrl_q[`SPI_CTRL_IE];
assign ctrl.pr_sel = ctrl_q[`SPI_CTRL_PR_MSB:`SPI_CTRL_PR_LSB];

assign tx_byte = tx_buf;
assign tx_valid = ~txe; // Pending byte for the shifter

always_ff @(posedge sys) begin
	if (!n_sh_reset) begin
		ctrl_q <= 8'h00;
	end else if (wr_ctrl) begin
		ctrl_q <= bus.wdata & `SPI_CTRL_MASK;
	end
end

always_ff @(posedge sys) begin
	if (wr_data) begin
		tx_buf <= bus.wdata;
	end
end

// Receive register, overwritten by every completed byte
always_ff @(posedge sys) begin
	if (!n_sh_reset) begin
		rx_buf <= 8'h00;
	end else if (!ctrl.enabled) begin
		rx_buf <= 8'h00;
	end else if (stat.done) begin
		rx_buf <= stat.rx_byte;
	end
end

// Flag next state
always_comb begin
	txe_d = txe;
	rxne_d = rxne;
	if (!ctrl.enabled) begin
		txe_d = 1'b1;
		rxne_d = 1'b0;
	end else begin
		if (wr_data) begin
			txe_d = 1'b0; // New byte wins over a load
		end else if (stat.loaded) begin
			txe_d = 1'b1;
		end
		if (stat.done) begin
			rxne_d = 1'b1; // Fresh byte wins over a read
		end else if (rd_data) begin
			rxne_d = 1'b0;
		end
	end
end

always_ff @(posedge sys) begin
	if (!n_sh_reset) begin
		txe <= 1'b1;
		rxne <= 1'b0;
		irq <= 1'b0;
	end else begin
		txe <= txe_d;
		rxne <= rxne_d;
		irq <= rxne_d & ctrl.ie; // Rises together with RXNE
	end
end

always_comb begin
	stat_word = 8'h00;
	stat_word[`SPI_STAT_TXE] = txe;
	stat_word[`SPI_STAT_RXNE] = rxne;
	stat_word[`SPI_STAT_BUSY] = stat.busy;
end

// Read mux, zero when not selected
always_comb begin
	rdata = 8'h00;
	if (rd) begin
		case (bus.addr)
			`SPI_CTRL: rdata = ctrl_q & `SPI_CTRL_MASK;
			`SPI_STAT: rdata = stat_word & `SPI_STAT_MASK;
			`SPI_DATA: rdata = rx_buf;
			default: rdata = 8'h00; // Unmapped
		endcase
	end
end

endmodule

// File: spi_shifter.sv
`timescale 1ns/1ns
`include "spi_settings.svh"

module spi_shifter
	import spi_pkg::*;
(
	input logic sys,
	input logic n_sh_reset,
	input spi_ctrl_t ctrl,
	input logic tick,
	input logic [7:0] tx_byte,
	input logic tx_valid,
	output shift_stat_t stat,
	output logic sck,
	output logic mosi,
	output logic ss_n,
	input logic miso
);

localparam logic ST_IDLE = 1'b0;
localparam logic ST_SHIFT = 1'b1;

logic state;
logic [4:0] tick_cnt; // Half periods done in this byte
logic [7:0] sh_data; // MSB out, LSB in
logic samp; // miso held from the leading edge
logic rx_bit;
logic done;
logic loaded;
logic lead;
logic trail;
logic last_trail;

// All 16 ticks seen, byte complete
assign done = (state == ST_SHIFT) && (tick_cnt == `SPI_XFER_TICKS);

// Take a byte when idle or while finishing the current one
assign loaded = ctrl.enabled && tx_valid && ((state == ST_IDLE) || done);

// Even ticks are leading edges, odd ticks trailing
assign lead = (state == ST_SHIFT) && tick && !done && !tick_cnt[0];
assign trail = (state == ST_SHIFT) && tick && !done && tick_cnt[0];
assign last_trail = trail && (tick_cnt == `SPI_XFER_TICKS - 5'd1);

// cpha=1 samples right at the trailing edge
assign rx_bit = ctrl.cpha ? miso : samp;

assign stat.busy = (state == ST_SHIFT);
assign stat.loaded = loaded;
assign stat.done = done;
assign stat.rx_byte = sh_data;

always_ff @(posedge sys) begin
	if (!n_sh_reset) begin
		state <= ST_IDLE;
		tick_cnt <= '0;
		sck <= 1'b0;
		mosi <= 1'b0;
		ss_n <= 1'b1;
	end else if (!ctrl.enabled) begin
		state <= ST_IDLE; // Abort any transfer
		tick_cnt <= '0;
		sck <= ctrl.cpol;
		mosi <= 1'b0;
		ss_n <= 1'b1;
	end else if (loaded) begin
		state <= ST_SHIFT;
		tick_cnt <= '0;
		sck <= ctrl.cpol;
		ss_n <= 1'b0; // Stays low on back-to-back bytes
		if (!ctrl.cpha) begin
			mosi <= tx_byte[7]; // Set up before the first leading edge
		end
	end else if (done) begin
		state <= ST_IDLE;
		tick_cnt <= '0;
		sck <= ctrl.cpol;
		ss_n <= 1'b1;
	end else if (state == ST_SHIFT) begin
		if (tick) begin
			tick_cnt <= tick_cnt + 5'd1;
			sck <= ~sck;
		end
		if (lead && ctrl.cpha) begin
			mosi <= sh_data[7]; // Change on the leading edge
		end
		if (trail && !ctrl.cpha && !last_trail) begin
			mosi <= sh_data[6]; // Next bit, before it shifts up
		end
	end else begin
		sck <= ctrl.cpol; // Idle level follows CPOL
	end
end

// Data path
always_ff @(posedge sys) begin
	if (loaded) begin
		sh_data <= tx_byte;
	end else if (trail) begin
		sh_data <= {sh_data[6:0], rx_bit};
	end
	if (lead) begin
		samp <= miso;
	end
end

endmodule

// File: spi_periph_top.sv
`timescale 1ns/1ns

module spi_periph_top
	import spi_pkg::*;
(
	input logic sys,
	input logic n_sh_reset,
	input pbus_req_t bus,
	output logic [7:0] rdata,
	output logic sck,
	output logic mosi,
	input logic miso,
	output logic ss_n,
	output logic irq
);

spi_ctrl_t ctrl;
shift_stat_t stat;
logic tick;
logic [7:0] tx_byte;
logic tx_valid;

prescaler prescaler_inst (
	.sys(sys),
	.n_sh_reset(n_sh_reset),
	.ctrl(ctrl),
	.tick(tick)
);

spi_regs spi_regs_inst (
	.sys(sys),
	.n_sh_reset(n_sh_reset),
	.bus(bus),
	.rdata(rdata),
	.ctrl(ctrl),
	.tx_byte(tx_byte),
	.tx_valid(tx_valid),
	.stat(stat),
	.irq(irq)
);

spi_shifter spi_shifter_inst (
	.sys(sys),
	.n_sh_reset(n_sh_reset),
	.ctrl(ctrl),
	.tick(tick),
	.tx_byte(tx_byte),
	.tx_valid(tx_valid),
	.stat(stat),
	.sck(sck),
	.mosi(mosi),
	.ss_n(ss_n),
	.miso(miso)
);

endmodule

// File: spi_periph_top_tb.sv
`timescale 1ns/1ns
`include "spi_settings.svh"

module spi_periph_top_tb
	import spi_pkg::*;
();

localparam int WAIT_LIMIT = 6000; // Per-wait bound in sys cycles

logic sys;
logic n_sh_reset;
pbus_req_t bus;
logic [7:0] rdata;
logic sck;
logic mosi;
logic miso = 1'b0;
logic ss_n;
logic irq;

integer seed = 32'hce92_a3c2;
int errors = 0;
int test_errs = 0;
int tests_run = 0;
int failed_tests = 0;
logic cur_cpol = 1'b0; // Mode the slave model follows
logic cur_cpha = 1'b0;

// SPI slave model state
logic [7:0] miso_q[$]; // Bytes the slave sends
logic [7:0] mosi_q[$]; // Bytes the slave collected
logic [7:0] s_shift = 8'h00;
logic [7:0] s_rx = 8'h00;
int s_bits = 0;
logic ss_prev = 1'b1;
logic sck_prev = 1'b0;

spi_periph_top spi_periph_top_inst (
	.sys(sys),
	.n_sh_reset(n_sh_reset),
	.bus(bus),
	.rdata(rdata),
	.sck(sck),
	.mosi(mosi),
	.miso(miso),
	.ss_n(ss_n),
	.irq(irq)
);

initial begin
	sys = 1'b0;
	forever #4 sys = ~sys;
end

// Slave reacts to select and to every sck edge
always @(sck or ss_n) begin
	if (ss_prev && !ss_n) begin
		s_bits = 0;
		s_rx = 8'h00;
		s_shift = (miso_q.size() > 0) ? miso_q.pop_front() : 8'h00;
		if (!cur_cpha) miso = s_shift[7];
	end else if (!ss_n && (sck != sck_prev)) begin
		if (sck != cur_cpol) begin // Leading edge
			if (cur_cpha) miso = s_shift[7];
			else s_rx = {s_rx[6:0], mosi};
		end else begin // Trailing edge
			if (cur_cpha) s_rx = {s_rx[6:0], mosi};
			s_shift = {s_shift[6:0], 1'b0};
			s_bits++;
			if (s_bits == 8) begin
				mosi_q.push_back(s_rx);
				s_bits = 0;
				s_shift = (miso_q.size() > 0) ? miso_q.pop_front() : 8'h00;
			end
			if (!cur_cpha) miso = s_shift[7];
		end
	end
	ss_prev = ss_n;
	sck_prev = sck;
end

// sck rests at CPOL whenever the slave is deselected
sck_idle: assert property (@(posedge sys) disable iff (!n_sh_reset) ss_n |-> (sck == cur_cpol))
	else begin
		$display("Fail sck idle level: sck=%h cpol=%h", sck, cur_cpol);
		errors++;
	end

task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
	assert (got == exp) else begin
		$display("Fail %s: got %h expected %h", name, got, exp);
		errors++;
	end
endtask

task automatic report_timeout(input string what);
	$display("Timeout while waiting for %s", what);
	errors++;
endtask

// Bus tasks start on a falling edge and return on the next one
task automatic bus_write(input logic [1:0] addr, input logic [7:0] data);
	bus.sel = 1'b1;
	bus.we = 1'b1;
	bus.addr = addr;
	bus.wdata = data;
	@(negedge sys);
	bus.sel = 1'b0;
	bus.we = 1'b0;
endtask

task automatic bus_read(input logic [1:0] addr, output logic [7:0] data);
	bus.sel = 1'b1;
	bus.we = 1'b0;
	bus.addr = addr;
	#2 data = rdata; // Mid low phase, stable
	@(negedge sys);
	bus.sel = 1'b0;
endtask

// Slave model switches mode once sck has settled
task automatic write_ctrl(input logic [7:0] value);
	bus_write(`SPI_CTRL, value);
	@(negedge sys);
	cur_cpol = value[`SPI_CTRL_CPOL];
	cur_cpha = value[`SPI_CTRL_CPHA];
endtask

function automatic logic [7:0] mode_ctrl(input logic cpol, input logic cpha,
	input logic [2:0] pr);
	logic [7:0] c;
	c = 8'h00;
	c[`SPI_CTRL_EN] = 1'b1;
	c[`SPI_CTRL_CPOL] = cpol;
	c[`SPI_CTRL_CPHA] = cpha;
	c[`SPI_CTRL_PR_MSB:`SPI_CTRL_PR_LSB] = pr;
	return c;
endfunction

task automatic wait_status(input int bitpos, input logic val, input string what,
	output logic [7:0] last);
	bit hit;
	hit = 0;
	last = 8'h00;
	for (int n = 0; n < WAIT_LIMIT && !hit; n++) begin
		bus_read(`SPI_STAT, last);
		if (last[bitpos] == val) hit = 1;
	end
	if (!hit) report_timeout(what);
endtask

task automatic wait_ss(input logic val);
	bit hit;
	hit = 0;
	for (int n = 0; n < WAIT_LIMIT && !hit; n++) begin
		if (ss_n == val) hit = 1;
		else @(negedge sys);
	end
	if (!hit) report_timeout("ss_n to change");
endtask

task automatic wait_sck_change(output int cycles);
	logic last;
	bit hit;
	hit = 0;
	last = sck;
	cycles = 0;
	while (cycles < WAIT_LIMIT && !hit) begin
		@(negedge sys);
		cycles++;
		if (sck != last) hit = 1;
	end
	if (!hit) report_timeout("an sck edge");
endtask

task automatic single_transfer(input logic [7:0] tx, input logic [7:0] sb);
	logic [7:0] v;
	miso_q.delete();
	mosi_q.delete();
	miso_q.push_back(sb);
	bus_write(`SPI_DATA, tx);
	bus_read(`SPI_STAT, v);
	check_value("STAT.TXE after write", {7'h0, v[`SPI_STAT_TXE]}, 8'h00);
	wait_status(`SPI_STAT_TXE, 1'b1, "TXE to set", v);
	check_value("STAT.RXNE at TXE", {7'h0, v[`SPI_STAT_RXNE]}, 8'h00);
	check_value("STAT.BUSY at TXE", {7'h0, v[`SPI_STAT_BUSY]}, 8'h01);
	wait_status(`SPI_STAT_RXNE, 1'b1, "RXNE to set", v);
	wait_ss(1'b1);
	bus_read(`SPI_DATA, v);
	check_value("DATA", v, sb);
	bus_read(`SPI_STAT, v);
	check_value("STAT.RXNE after read", {7'h0, v[`SPI_STAT_RXNE]}, 8'h00);
	check_value("slave byte count", 8'(mosi_q.size()), 8'd1);
	if (mosi_q.size() > 0) begin
		check_value("slave mosi byte", mosi_q[0], tx);
	end
endtask

task automatic finish_test(input string name);
	tests_run++;
	if (errors == test_errs) begin
		$display("Test %s: ok", name);
	end else begin
		$display("Test %s: %0d errors", name, errors - test_errs);
		failed_tests++;
	end
	test_errs = errors;
endtask

initial begin
	#3000000;
	$display("Simulation watchdog expired");
	$display("TB FAILED");
	$finish;
end

initial begin
	logic [7:0] v;
	logic [7:0] b1;
	logic [7:0] b2;
	logic [7:0] s1;
	logic [7:0] s2;
	int cycles;
	bit two;
	n_sh_reset = 1'b0;
	bus = '0;
	repeat (2) @(negedge sys);
	n_sh_reset = 1'b1;
	@(negedge sys);

	// Reset values and register access
	bus_read(`SPI_STAT, v);
	check_value("STAT", v, 8'h01);
	bus_read(`SPI_CTRL, v);
	check_value("CTRL", v, 8'h00);
	check_value("sck", {7'h0, sck}, 8'h00);
	check_value("ss_n", {7'h0, ss_n}, 8'h01);
	write_ctrl(8'hff);
	bus_read(`SPI_CTRL, v);
	check_value("CTRL", v, 8'hbf); // Bit 6 reads as zero
	write_ctrl(8'h00);
	bus_read(2'd3, v);
	check_value("unmapped read", v, 8'h00);
	bus.sel = 1'b0;
	bus.addr = `SPI_STAT;
	#2 check_value("rdata with sel low", rdata, 8'h00);
	@(negedge sys);
	finish_test("reset_and_registers");

	// One byte in each SPI mode
	for (int m = 0; m < 4; m++) begin
		write_ctrl(mode_ctrl(m[1], m[0], 3'd1));
		single_transfer(8'($random(seed)), 8'($random(seed)));
	end
	finish_test("four_modes");

	// sck half period follows pr_sel
	for (int p = 1; p < 4; p += 2) begin
		write_ctrl(mode_ctrl(1'b0, 1'b0, 3'(p)));
		miso_q.delete();
		miso_q.push_back(8'($random(seed)));
		bus_write(`SPI_DATA, 8'($random(seed)));
		wait_ss(1'b0);
		wait_sck_change(cycles);
		wait_sck_change(cycles);
		check_value("sck half period", 8'(cycles), 8'(2 ** (p + 1)));
		wait_status(`SPI_STAT_RXNE, 1'b1, "RXNE after rate check", v);
		wait_ss(1'b1);
		bus_read(`SPI_DATA, v);
	end
	finish_test("rate_select");

	// Second byte buffered while the first shifts
	write_ctrl(mode_ctrl(1'b1, 1'b0, 3'd0));
	b1 = 8'($random(seed));
	b2 = 8'($random(seed));
	s1 = 8'($random(seed));
	s2 = 8'($random(seed));
	miso_q.delete();
	mosi_q.delete();
	miso_q.push_back(s1);
	miso_q.push_back(s2);
	bus_write(`SPI_DATA, b1);
	wait_status(`SPI_STAT_TXE, 1'b1, "TXE before second byte", v);
	bus_write(`SPI_DATA, b2);
	two = 0;
	for (int n = 0; n < WAIT_LIMIT && !two; n++) begin
		@(negedge sys);
		if (mosi_q.size() >= 2) begin
			two = 1;
		end else if (ss_n) begin
			check_value("ss_n between buffered bytes", {7'h0, ss_n}, 8'h00);
			two = 1;
		end
	end
	if (!two) report_timeout("two slave bytes");
	wait_ss(1'b1);
	wait_status(`SPI_STAT_RXNE, 1'b1, "RXNE after two bytes", v);
	bus_read(`SPI_DATA, v);
	check_value("DATA after two bytes", v, s2);
	check_value("slave byte count", 8'(mosi_q.size()), 8'd2);
	if (mosi_q.size() >= 2) begin
		check_value("slave first byte", mosi_q[0], b1);
		check_value("slave second byte", mosi_q[1], b2);
	end
	finish_test("back_to_back");

	// Interrupt, then abort by clearing EN
	v = mode_ctrl(1'b1, 1'b1, 3'd1);
	v[`SPI_CTRL_IE] = 1'b1;
	write_ctrl(v);
	s1 = 8'($random(seed));
	miso_q.delete();
	miso_q.push_back(s1);
	bus_write(`SPI_DATA, 8'($random(seed)));
	two = 0;
	for (int n = 0; n < WAIT_LIMIT && !two; n++) begin
		if (irq) two = 1;
		else @(negedge sys);
	end
	if (!two) report_timeout("irq to rise");
	bus_read(`SPI_STAT, v);
	check_value("STAT.RXNE with irq", {7'h0, v[`SPI_STAT_RXNE]}, 8'h01);
	bus_read(`SPI_DATA, v);
	check_value("DATA with irq", v, s1);
	check_value("irq after read", {7'h0, irq}, 8'h00);
	bus_write(`SPI_DATA, 8'($random(seed)));
	wait_ss(1'b0);
	wait_sck_change(cycles); // sck now away from its idle level
	write_ctrl(mode_ctrl(1'b1, 1'b1, 3'd1) & ~8'h80);
	@(negedge sys);
	check_value("ss_n after disable", {7'h0, ss_n}, 8'h01);
	check_value("sck after disable", {7'h0, sck}, 8'h01);
	bus_read(`SPI_STAT, v);
	check_value("STAT after disable", v, 8'h01);
	finish_test("irq_and_disable");

	$display("Tests run %0d, failed %0d, errors %0d", tests_run, failed_tests, errors);
	if (errors == 0) begin
		$display("TB PASSED");
	end else begin
		$display("TB FAILED");
	end
	$finish;
end

endmodule

// File: spi_periph_top.f
+incdir+.
spi_pkg.sv
prescaler.sv
spi_regs.sv
spi_shifter.sv
spi_periph_top.sv
spi_periph_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the SPI peripheral testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module spi_periph_top_tb \
	-f spi_periph_top.f \
	-Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vspi_periph_top_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "TB PASSED" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi
